// File: common/spi_macros.svh
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// widest frame carried by the shifters and the FIFOs
`define SPI_MAX_BITS 16

// FIFO depths in words
`define SPI_TX_DEPTH 8
`define SPI_RX_DEPTH 8

// clock divider counter, same width as the clock_period field
`define SPI_CLKDIV_W 12

// inter-cs, c2t, t2c and inter-frame delay counters
`define SPI_DLY_W 8

// one delay unit is 2**SPI_UNIT_W divider periods
`define SPI_UNIT_W 2

// sclk edge counter, two edges per frame bit
`define SPI_EDGE_W 5

`endif

// File: common/spi_pkg.sv
`include "spi_macros.svh"

package spi_pkg;

    // controller FSM states
    typedef enum logic [2:0] {
        spi_st_idle       = 3'd0,
        spi_st_load_data  = 3'd1,
        spi_st_wait       = 3'd2,
        spi_st_trans      = 3'd3,
        spi_st_turnaround = 3'd4,
        spi_st_interval   = 3'd5
    } spi_state_e;

    // one frame of serial data, right aligned
    typedef logic [`SPI_MAX_BITS-1:0] spi_word_t;

    // static settings, held stable while the controller is busy
    typedef struct packed {
        // system clocks per sclk half period, minus one
        logic [`SPI_CLKDIV_W-1:0] clock_period;
        logic                     cpha;
        logic                     cpol;
        // 2 and 3 keep chip select asserted between frames
        logic [1:0]               cs_mode;
        // delays counted in delay units
        logic [`SPI_DLY_W-1:0]    c2t_time;
        logic [`SPI_DLY_W-1:0]    t2c_time;
        logic [`SPI_DLY_W-1:0]    inter_cs_time;
        logic [`SPI_DLY_W-1:0]    inter_frame_time;
        // frame bits minus one
        logic [3:0]               data_size;
        // idle level of the chip select lines
        logic [1:0]               cs_default;
        // lines flipped away from their idle level during a transfer
        logic [1:0]               cs_id;
        logic                     rx_wr_disable;
    } spi_cfg_t;

endpackage

// File: hw/spi_fifo.sv
`timescale 1ns/100ps

module spi_fifo #(
    parameter int unsigned DEPTH = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push_i,
    input  spi_pkg::spi_word_t data_i,
    input  logic               pop_i,
    output spi_pkg::spi_word_t data_o,
    output logic               full_o,
    output logic               empty_o
);

    localparam int unsigned      PTR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned      CNT_W    = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    spi_pkg::spi_word_t mem_q [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               do_push;
    logic               do_pop;

    assign full_o  = (count_q == FULL_CNT);
    assign empty_o = (count_q == '0);

    // pushes while full and pops while empty are ignored
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // head word shows on the output without a read cycle
    assign data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// File: hw/spi_datapath.sv
`timescale 1ns/100ps

`include "spi_macros.svh"

module spi_datapath (
    input  logic               clk,
    input  logic               rst_n,
    input  spi_pkg::spi_cfg_t  cfg_i,
    input  spi_pkg::spi_word_t tx_word_i,
    input  logic               tx_shift_load_i,
    input  logic               mosi_first_transmit_i,
    input  logic               mosi_en_i,
    input  logic               miso_en_i,
    input  logic               mosi_sel_i,
    input  logic               miso_i,
    output logic               mosi_o,
    output spi_pkg::spi_word_t rx_word_o
);

    spi_pkg::spi_word_t tx_shreg_q;
    spi_pkg::spi_word_t rx_shreg_q;
    logic               mosi_bit_q;
    logic               tx_shift;

    // both strobes move the next bit onto the line
    assign tx_shift = mosi_first_transmit_i | mosi_en_i;

    // tx shifter, frame MSB sits at bit data_size of the loaded word
    always_ff @(posedge clk) begin
        if (tx_shift_load_i) begin
            tx_shreg_q <= tx_word_i;
        end else if (tx_shift) begin
            tx_shreg_q <= tx_shreg_q << 1;
        end
    end

    // line bit changes on the same clock as the sclk shift edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mosi_bit_q <= 1'b0;
        end else if (tx_shift) begin
            mosi_bit_q <= tx_shreg_q[cfg_i.data_size];
        end
    end

    // rx shifter fills from the LSB, so the finished frame is right aligned
    always_ff @(posedge clk) begin
        if (tx_shift_load_i) begin
            rx_shreg_q <= '0;
        end else if (miso_en_i) begin
            rx_shreg_q <= {rx_shreg_q[`SPI_MAX_BITS-2:0], miso_i};
        end
    end

    // mosi is held low outside the transfer window
    assign mosi_o    = mosi_sel_i & mosi_bit_q;
    assign rx_word_o = rx_shreg_q;

endmodule

// File: spi_controller/spi_controller.sv
`timescale 1ns/100ps

`include "spi_macros.svh"

module spi_controller (
    input  logic              clk,
    input  logic              rst_n,
    input  spi_pkg::spi_cfg_t cfg_i,
    input  logic              tx_fifo_empty_i,
    output logic [1:0]        cs_o,
    output logic              busy_o,
    output logic              hold_off_o,
    output logic              mosi_first_transmit_o,
    output logic              mosi_en_o,
    output logic              miso_en_o,
    output logic              tx_shift_load_o,
    output logic              tx_fifo_read_o,
    output logic              rx_fifo_write_o,
    output logic              mosi_sel_o,
    output logic              sclk_o
);

    spi_pkg::spi_state_e state_q;
    spi_pkg::spi_state_e state_d;

    logic [`SPI_CLKDIV_W-1:0] clk_cnt_q;
    logic [`SPI_UNIT_W-1:0]   unit_cnt_q;
    logic [`SPI_DLY_W-1:0]    dly_cnt_q;
    logic [`SPI_DLY_W-1:0]    dly_target;
    logic [`SPI_EDGE_W-1:0]   edge_cnt_q;
    logic [`SPI_EDGE_W-1:0]   last_edge;
    logic                     state_change;
    logic                     first_q;
    logic                     div_tick;
    logic                     unit_tick;
    logic                     sclk_tick;
    logic                     dly_done;
    logic                     frame_end;
    logic                     hold_mode;
    logic                     sclk_phase_q;
    logic                     cs_active_q;
    logic                     rx_wr_q;

    assign state_change = (state_q != state_d);
    assign hold_mode    = cfg_i.cs_mode[1];

    // divider and delay unit ticks
    assign div_tick  = (clk_cnt_q == cfg_i.clock_period);
    assign unit_tick = div_tick && (&unit_cnt_q);

    // the first trans cycle is a setup slot for the cpha=0 first bit
    assign sclk_tick = (state_q == spi_pkg::spi_st_trans) && !first_q && div_tick;

    // 2*(data_size+1) edges per frame, the last one returns sclk to cpol
    assign last_edge = {cfg_i.data_size, 1'b1};
    assign frame_end = sclk_tick && (edge_cnt_q == last_edge);

    // delay length for the current gap state
    always_comb begin
        case (state_q)
            spi_pkg::spi_st_load_data:  dly_target = cfg_i.inter_cs_time;
            spi_pkg::spi_st_wait:       dly_target = cfg_i.c2t_time;
            spi_pkg::spi_st_turnaround: dly_target = cfg_i.inter_frame_time;
            spi_pkg::spi_st_interval:   dly_target = cfg_i.t2c_time;
            default:                    dly_target = '0;
        endcase
    end

    assign dly_done = (dly_cnt_q == dly_target);

    always_comb begin
        state_d = state_q;
        case (state_q)
            spi_pkg::spi_st_idle: begin
                if (!tx_fifo_empty_i) begin
                    state_d = spi_pkg::spi_st_load_data;
                end
            end
            spi_pkg::spi_st_load_data: begin
                if (dly_done) begin
                    state_d = spi_pkg::spi_st_wait;
                end
            end
            spi_pkg::spi_st_wait: begin
                if (dly_done) begin
                    state_d = spi_pkg::spi_st_trans;
                end
            end
            spi_pkg::spi_st_trans: begin
                if (frame_end) begin
                    // hold mode chains frames only while words are waiting
                    if (hold_mode && !tx_fifo_empty_i) begin
                        state_d = spi_pkg::spi_st_turnaround;
                    end else begin
                        state_d = spi_pkg::spi_st_interval;
                    end
                end
            end
            spi_pkg::spi_st_turnaround: begin
                if (dly_done) begin
                    state_d = spi_pkg::spi_st_trans;
                end
            end
            spi_pkg::spi_st_interval: begin
                if (dly_done) begin
                    state_d = spi_pkg::spi_st_idle;
                end
            end
            default: state_d = spi_pkg::spi_st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= spi_pkg::spi_st_idle;
            first_q    <= 1'b0;
            clk_cnt_q  <= '0;
            unit_cnt_q <= '0;
            dly_cnt_q  <= '0;
            edge_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            first_q <= (state_d == spi_pkg::spi_st_trans) && (state_q != spi_pkg::spi_st_trans);
            // all timing counters restart on every state change
            if (state_change || div_tick) begin
                clk_cnt_q <= '0;
            end else if (!first_q) begin
                clk_cnt_q <= clk_cnt_q + 1'b1;
            end
            if (state_change) begin
                unit_cnt_q <= '0;
                dly_cnt_q  <= '0;
                edge_cnt_q <= '0;
            end else begin
                if (div_tick) begin
                    unit_cnt_q <= unit_cnt_q + 1'b1;
                end
                if (unit_tick) begin
                    dly_cnt_q <= dly_cnt_q + 1'b1;
                end
                if (sclk_tick) begin
                    edge_cnt_q <= edge_cnt_q + 1'b1;
                end
            end
        end
    end

    // sclk phase relative to cpol, chip select active flag, delayed rx push
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_phase_q <= 1'b0;
            cs_active_q  <= 1'b0;
            rx_wr_q      <= 1'b0;
        end else begin
            if (state_q != spi_pkg::spi_st_trans) begin
                sclk_phase_q <= 1'b0;
            end else if (sclk_tick) begin
                sclk_phase_q <= ~sclk_phase_q;
            end
            if ((state_q == spi_pkg::spi_st_load_data) && dly_done) begin
                cs_active_q <= 1'b1;
            end else if (state_d == spi_pkg::spi_st_idle) begin
                cs_active_q <= 1'b0;
            end
            // one cycle late so the final cpha=1 sample is already in the shifter
            rx_wr_q <= frame_end && !cfg_i.rx_wr_disable;
        end
    end

    assign sclk_o = cfg_i.cpol ^ sclk_phase_q;
    assign cs_o   = cs_active_q ? (cfg_i.cs_default ^ cfg_i.cs_id) : cfg_i.cs_default;

    // cpha=0 shifts on trailing edges and samples on leading edges, cpha=1 the opposite
    assign mosi_first_transmit_o = first_q && !cfg_i.cpha;
    assign mosi_en_o = sclk_tick && (cfg_i.cpha ? !edge_cnt_q[0]
                                                : (edge_cnt_q[0] && (edge_cnt_q != last_edge)));
    assign miso_en_o = sclk_tick && (edge_cnt_q[0] == cfg_i.cpha);

    // head word is loaded and popped together when a gap before a frame ends
    assign tx_shift_load_o = dly_done && ((state_q == spi_pkg::spi_st_load_data) ||
                                          (state_q == spi_pkg::spi_st_turnaround));
    assign tx_fifo_read_o  = tx_shift_load_o;
    assign rx_fifo_write_o = rx_wr_q;

    assign mosi_sel_o = (state_q == spi_pkg::spi_st_trans);
    assign busy_o     = (state_q != spi_pkg::spi_st_idle);
    assign hold_off_o = (state_q == spi_pkg::spi_st_idle) ||
                        (state_q == spi_pkg::spi_st_turnaround);

endmodule

// File: hw/spi_master_top.sv
`timescale 1ns/100ps

`include "spi_macros.svh"

module spi_master_top (
    input  logic               clk,
    input  logic               rst_n,
    input  spi_pkg::spi_cfg_t  cfg_i,
    input  logic               tx_push_i,
    input  spi_pkg::spi_word_t tx_wdata_i,
    input  logic               rx_pop_i,
    input  logic               miso_i,
    output logic               tx_full_o,
    output spi_pkg::spi_word_t rx_rdata_o,
    output logic               rx_empty_o,
    output logic               busy_o,
    output logic               hold_off_o,
    output logic               sclk_o,
    output logic               mosi_o,
    output logic [1:0]         cs_o
);

    spi_pkg::spi_word_t tx_head;
    spi_pkg::spi_word_t rx_word;
    logic               tx_empty;
    logic               tx_fifo_read;
    logic               tx_shift_load;
    logic               mosi_first_transmit;
    logic               mosi_en;
    logic               miso_en;
    logic               mosi_sel;
    logic               rx_fifo_write;

    spi_fifo #(
        .DEPTH (`SPI_TX_DEPTH)
    ) i_tx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (tx_push_i),
        .data_i  (tx_wdata_i),
        .pop_i   (tx_fifo_read),
        .data_o  (tx_head),
        .full_o  (tx_full_o),
        .empty_o (tx_empty)
    );

    // rx overflow is not reported, extra words are dropped
    spi_fifo #(
        .DEPTH (`SPI_RX_DEPTH)
    ) i_rx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (rx_fifo_write),
        .data_i  (rx_word),
        .pop_i   (rx_pop_i),
        .data_o  (rx_rdata_o),
        .full_o  (),
        .empty_o (rx_empty_o)
    );

    spi_datapath i_spi_datapath (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .cfg_i                 (cfg_i),
        .tx_word_i             (tx_head),
        .tx_shift_load_i       (tx_shift_load),
        .mosi_first_transmit_i (mosi_first_transmit),
        .mosi_en_i             (mosi_en),
        .miso_en_i             (miso_en),
        .mosi_sel_i            (mosi_sel),
        .miso_i                (miso_i),
        .mosi_o                (mosi_o),
        .rx_word_o             (rx_word)
    );

    spi_controller i_spi_controller (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .cfg_i                 (cfg_i),
        .tx_fifo_empty_i       (tx_empty),
        .cs_o                  (cs_o),
        .busy_o                (busy_o),
        .hold_off_o            (hold_off_o),
        .mosi_first_transmit_o (mosi_first_transmit),
        .mosi_en_o             (mosi_en),
        .miso_en_o             (miso_en),
        .tx_shift_load_o       (tx_shift_load),
        .tx_fifo_read_o        (tx_fifo_read),
        .rx_fifo_write_o       (rx_fifo_write),
        .mosi_sel_o            (mosi_sel),
        .sclk_o                (sclk_o)
    );

endmodule

// File: tb/tb_spi_master.sv
`timescale 1ns/100ps

module tb_spi_master;

    localparam int NUM_TESTS = 12;
    localparam int MAX_WORDS = 6;

    logic               clk = 1'b0;
    logic               rst_n;
    spi_pkg::spi_cfg_t  cfg;
    logic               tx_push;
    spi_pkg::spi_word_t tx_wdata;
    logic               rx_pop;
    logic               miso;
    logic               tx_full;
    spi_pkg::spi_word_t rx_rdata;
    logic               rx_empty;
    logic               busy;
    logic               hold_off;
    logic               sclk;
    logic               mosi;
    logic [1:0]         cs;

    // burst list built before reset
    spi_pkg::spi_cfg_t test_cfg [NUM_TESTS];
    int                test_words [NUM_TESTS];
    int                watchdog_cycles;
    logic              plan_ready;
    logic [31:0]       lcg_state;
    string             test_name;

    // scoreboard queues
    spi_pkg::spi_word_t mosi_exp_q[$];
    spi_pkg::spi_word_t reply_q[$];
    spi_pkg::spi_word_t rx_exp_q[$];

    // slave model state
    logic               sclk_prev;
    logic               mosi_prev;
    logic               leading;
    logic               saw_cs_idle;
    int                 bit_idx;
    int                 burst_frames;
    int                 miso_idx;
    spi_pkg::spi_word_t mosi_cap;

    spi_master_top i_spi_master_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_i      (cfg),
        .tx_push_i  (tx_push),
        .tx_wdata_i (tx_wdata),
        .rx_pop_i   (rx_pop),
        .miso_i     (miso),
        .tx_full_o  (tx_full),
        .rx_rdata_o (rx_rdata),
        .rx_empty_o (rx_empty),
        .busy_o     (busy),
        .hold_off_o (hold_off),
        .sclk_o     (sclk),
        .mosi_o     (mosi),
        .cs_o       (cs)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // value in lo..hi taken from the upper LCG bits
    function automatic int pick(int lo, int hi);
        logic [31:0] r;
        r = next_rand();
        return lo + int'(r[31:8] % (hi - lo + 1));
    endfunction

    function automatic spi_pkg::spi_word_t frame_mask(logic [3:0] data_size);
        int n;
        n = int'(data_size) + 1;
        return spi_pkg::spi_word_t'((32'd1 << n) - 1);
    endfunction

    task automatic compare_word(string what, spi_pkg::spi_word_t exp,
                                spi_pkg::spi_word_t act);
        if (act !== exp) begin
            $display("** Error: test %s, %s: expected %h, actual %h", test_name, what, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic compare_bit(string what, logic exp, logic act);
        if (act !== exp) begin
            $display("** Error: test %s, %s: expected %b, actual %b", test_name, what, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic compare_cs(string what, logic [1:0] exp, logic [1:0] act);
        if (act !== exp) begin
            $display("** Error: test %s, %s: expected %b, actual %b", test_name, what, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_failure(string msg);
        $display("test %s failed: %s", test_name, msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first failure");
    endtask

    // random settings per burst with all four cpol/cpha modes in turn
    task automatic build_tests();
        spi_pkg::spi_cfg_t c;
        int                dly_sum;
        watchdog_cycles = 2000 + 10;
        for (int t = 0; t < NUM_TESTS; t++) begin
            c = '0;
            c.cpol             = t[1];
            c.cpha             = t[0];
            c.clock_period     = 12'(pick(0, 3));
            c.c2t_time         = 8'(pick(0, 3));
            c.t2c_time         = 8'(pick(0, 3));
            c.inter_cs_time    = 8'(pick(0, 3));
            c.inter_frame_time = 8'(pick(0, 3));
            c.data_size        = 4'(pick(3, 15));
            c.cs_default       = 2'(pick(0, 3));
            // nonzero so the selected lines differ from idle
            c.cs_id            = 2'(pick(1, 3));
            if (t < 8) begin
                c.cs_mode       = {(t >= 4), 1'(pick(0, 1))};
                c.rx_wr_disable = 1'b0;
                test_words[t]   = pick(3, MAX_WORDS);
            end else begin
                c.cs_mode       = 2'(pick(0, 3));
                c.rx_wr_disable = 1'b1;
                test_words[t]   = pick(2, MAX_WORDS);
            end
            test_cfg[t] = c;
            dly_sum = c.c2t_time + c.t2c_time + c.inter_cs_time + c.inter_frame_time + 1;
            // bit time plus gap time where a delay unit is four divider periods
            watchdog_cycles += test_words[t] * (c.clock_period + 1) *
                               ((c.data_size + 1) * 2 * 4 + 16 * dly_sum);
        end
    endtask

    task automatic check_reset();
        compare_bit("busy after reset", 1'b0, busy);
        compare_bit("hold_off after reset", 1'b1, hold_off);
        compare_cs("cs after reset", cfg.cs_default, cs);
        compare_bit("sclk after reset", cfg.cpol, sclk);
        compare_bit("rx empty after reset", 1'b1, rx_empty);
    endtask

    task automatic run_burst(int t);
        spi_pkg::spi_word_t words[$];
        spi_pkg::spi_word_t w;
        spi_pkg::spi_word_t r;
        spi_pkg::spi_word_t mask;
        spi_pkg::spi_word_t exp;
        @(negedge clk);
        cfg = test_cfg[t];
        test_name = $sformatf("%s%0d_cpol%0d_cpha%0d_mode%0d",
                              cfg.rx_wr_disable ? "rxoff" : "burst", t,
                              cfg.cpol, cfg.cpha, cfg.cs_mode);
        mask = frame_mask(cfg.data_size);
        burst_frames = 0;
        @(negedge clk);
        compare_bit("idle sclk", cfg.cpol, sclk);
        compare_cs("idle cs", cfg.cs_default, cs);
        for (int i = 0; i < test_words[t]; i++) begin
            w = spi_pkg::spi_word_t'(next_rand() >> 16);
            r = spi_pkg::spi_word_t'(next_rand() >> 16);
            words.push_back(w);
            reply_q.push_back(r);
            mosi_exp_q.push_back(w & mask);
            if (!cfg.rx_wr_disable) begin
                rx_exp_q.push_back(r & mask);
            end
        end
        // back to back pushes of full words so the masking is exercised
        foreach (words[i]) begin
            compare_bit("tx full", 1'b0, tx_full);
            tx_push  = 1'b1;
            tx_wdata = words[i];
            @(negedge clk);
        end
        tx_push = 1'b0;
        while (busy || mosi_exp_q.size() != 0) begin
            @(negedge clk);
        end
        compare_cs("cs after burst", cfg.cs_default, cs);
        compare_bit("sclk after burst", cfg.cpol, sclk);
        compare_bit("hold_off after burst", 1'b1, hold_off);
        repeat (2) @(negedge clk);
        while (rx_exp_q.size() != 0) begin
            exp = rx_exp_q.pop_front();
            compare_bit("rx empty", 1'b0, rx_empty);
            compare_word("rx data", exp, rx_rdata);
            rx_pop = 1'b1;
            @(negedge clk);
            rx_pop = 1'b0;
        end
        compare_bit("rx empty at end", 1'b1, rx_empty);
    endtask

    task automatic finish_frame();
        spi_pkg::spi_word_t exp;
        if (mosi_exp_q.size() == 0) begin
            report_failure("a frame was sent with no word pushed");
        end
        exp = mosi_exp_q.pop_front();
        compare_word("mosi frame", exp, mosi_cap & frame_mask(cfg.data_size));
        void'(reply_q.pop_front());
        bit_idx      = 0;
        mosi_cap     = '0;
        saw_cs_idle  = 1'b0;
        burst_frames = burst_frames + 1;
    endtask

    // SPI slave model sampling the pins on the rising clock edge
    // an sclk change seen here was made by the previous clock edge
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_prev    = cfg.cpol;
            mosi_prev    = 1'b0;
            saw_cs_idle  = 1'b0;
            bit_idx      = 0;
            mosi_cap     = '0;
        end else begin
            if (cs == cfg.cs_default) begin
                saw_cs_idle = 1'b1;
                compare_bit("sclk idle level", cfg.cpol, sclk);
            end
            if (sclk != cfg.cpol) begin
                compare_cs("cs during transfer", cfg.cs_default ^ cfg.cs_id, cs);
            end
            if ((cs != cfg.cs_default) && (sclk != sclk_prev)) begin
                leading = (sclk != cfg.cpol);
                // cpha=0 samples on leading edges and cpha=1 on trailing ones
                if (leading != cfg.cpha) begin
                    if ((bit_idx == 0) && (burst_frames > 0)) begin
                        compare_bit("cs gap between frames", !cfg.cs_mode[1], saw_cs_idle);
                    end
                    mosi_cap = (mosi_cap << 1) | spi_pkg::spi_word_t'(mosi_prev);
                    bit_idx  = bit_idx + 1;
                    if (bit_idx == int'(cfg.data_size) + 1) begin
                        finish_frame();
                    end
                end
            end
            sclk_prev = sclk;
            mosi_prev = mosi;
        end
    end

    // reply bits go out MSB first and settle well before the next sample edge
    always @(negedge clk) begin
        miso_idx = int'(cfg.data_size) - bit_idx;
        if ((reply_q.size() != 0) && (miso_idx >= 0)) begin
            miso = reply_q[0][miso_idx];
        end else begin
            miso = 1'b0;
        end
    end

    initial begin
        lcg_state    = 32'h505cc1b4;
        plan_ready   = 1'b0;
        burst_frames = 0;
        rst_n        = 1'b0;
        tx_push      = 1'b0;
        tx_wdata     = '0;
        rx_pop       = 1'b0;
        miso         = 1'b0;
        test_name    = "reset";
        build_tests();
        cfg        = test_cfg[0];
        plan_ready = 1'b1;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_reset();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_burst(t);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        wait (plan_ready);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the bursts did not finish within %0d clock cycles", watchdog_cycles);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: vlog.f
+incdir+common
common/spi_pkg.sv
hw/spi_fifo.sv
hw/spi_datapath.sv
spi_controller/spi_controller.sv
hw/spi_master_top.sv
tb/tb_spi_master.sv

// File: Bender.yml
package:
  name: spi_master

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/spi_pkg.sv
      - hw/spi_fifo.sv
      - hw/spi_datapath.sv
      - spi_controller/spi_controller.sv
      - hw/spi_master_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_spi_master.sv
